// ==== sources.f ====
+incdir+src
src/rv_decode_pkg.sv
src/pipe_stage.sv
src/op_decoder.sv
src/pc_tracker.sv
src/decode_cfg.sv
src/rv_decode_top.sv
test/rv_decode_asserts.sv
test/tb_rv_decode.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the decode stage simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module tb_rv_decode -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "\*\* FAIL \*\*" sim.log; then
	exit 1
fi
if ! grep -q "\*\* PASS \*\*" sim.log; then
	exit 1
fi
exit 0

// ==== test/tb_rv_decode.sv ====
// Directed testbench for the decode stage that runs as the simulation top with the bound assertions
`timescale 1ns/1ps
`default_nettype none
`include "rv_decode_consts.svh"

module tb_rv_decode import rv_decode_pkg::*;;

	logic                 clk;
	logic                 rst_n;
	logic                 in_valid_i;
	logic                 in_ready_o;
	fetch_t               in_data_i;
	logic                 out_valid_o;
	logic                 out_ready_i;
	dec_t                 out_data_o;
	logic                 jump_valid_i;
	logic [`DEC_XLEN-1:0] jump_target_i;
	logic                 cfg_wr_i;
	cfg_write_t           cfg_wdata_i;
	cfg_status_t          cfg_rdata_o;

	logic [15:0] lfsr_state;
	logic [31:0] exp_pc;
	int          errors;
	int          tests;
	int          failed_tests;

	rv_decode_top u_dut (
		.clk           (clk),
		.rst_n         (rst_n),
		.in_valid_i    (in_valid_i),
		.in_ready_o    (in_ready_o),
		.in_data_i     (in_data_i),
		.out_valid_o   (out_valid_o),
		.out_ready_i   (out_ready_i),
		.out_data_o    (out_data_o),
		.jump_valid_i  (jump_valid_i),
		.jump_target_i (jump_target_i),
		.cfg_wr_i      (cfg_wr_i),
		.cfg_wdata_i   (cfg_wdata_i),
		.cfg_rdata_o   (cfg_rdata_o)
	);

	always #10 clk = !clk;

	// ------------------------------
	// Random bits and word encoding

	function automatic logic rand_bit();
		logic lsb;
		lsb = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (lsb) begin
			lfsr_state = lfsr_state ^ 16'hB400;
		end
		return lsb;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], rand_bit()};
		end
		return r;
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, `DEC_OPC_OP};
	endfunction

	function automatic logic [31:0] sext12(input logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	function automatic fetch_t fetch_word(input logic [31:0] w, input logic err);
		fetch_t f;
		f.instr = w;
		f.err   = err;
		return f;
	endfunction

	function automatic dec_t make_dec(input logic [31:0] imm, input logic [4:0] rs1,
			input logic [4:0] rs2, input logic [4:0] rd, input alusrc_a_e sa,
			input alusrc_b_e sb, input aluop_e op, input mulop_e mop, input memop_e mem,
			input bcond_e bc, input logic regoffs, input except_e ex);
		dec_t d;
		d.pc              = exp_pc;
		d.imm             = imm;
		d.rs1             = rs1;
		d.rs2             = rs2;
		d.rd              = rd;
		d.alusrc_a        = sa;
		d.alusrc_b        = sb;
		d.aluop           = op;
		d.mulop           = mop;
		d.memop           = mem;
		d.branchcond      = bc;
		d.addr_is_regoffs = regoffs;
		d.except          = ex;
		return d;
	endfunction

	// ------------------------------
	// Checks and reporting

	task automatic check_dec(input string name, input dec_t exp, input dec_t act);
		if (act !== exp) begin
			$display("Fail %s: expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_status(input string name, input cfg_status_t exp,
			input cfg_status_t act);
		if (act !== exp) begin
			$display("Fail %s: expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic abort_run(input string reason);
		$display("Timeout: %s", reason);
		$display("** FAIL **");
		$finish;
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests++;
		if (errors == errors_before) begin
			$display("%s: passed", name);
		end else begin
			$display("%s: failed", name);
			failed_tests++;
		end
	endtask

	// ------------------------------
	// Drivers and sink

	task automatic send_word(input fetch_t w);
		int n;
		n = 0;
		@(posedge clk);
		in_valid_i <= 1'b1;
		in_data_i  <= w;
		@(negedge clk);
		while (!in_ready_o) begin
			n++;
			if (n > 200) begin
				abort_run("input never accepted");
			end
			@(negedge clk);
		end
		@(posedge clk);
		in_valid_i <= 1'b0;
	endtask

	task automatic recv_word(output dec_t d);
		int n;
		n = 0;
		@(negedge clk);
		while (!(out_valid_o && out_ready_i)) begin
			n++;
			if (n > 200) begin
				abort_run("no decoded output appeared");
			end
			@(negedge clk);
		end
		d = out_data_o;
		@(posedge clk);
	endtask

	task automatic run_one(input string name, input fetch_t w, input dec_t exp);
		dec_t d;
		send_word(w);
		recv_word(d);
		check_dec(name, exp, d);
		exp_pc = exp_pc + 32'd4;
	endtask

	task automatic write_cfg(input logic m_en, input logic clr);
		@(posedge clk);
		cfg_wr_i              <= 1'b1;
		cfg_wdata_i.m_en      <= m_en;
		cfg_wdata_i.clr_count <= clr;
		@(posedge clk);
		cfg_wr_i <= 1'b0;
	endtask

	task automatic expect_status(input string name, input logic [15:0] cnt, input logic m_en);
		cfg_status_t s;
		s.ill_count = cnt;
		s.m_en      = m_en;
		@(negedge clk);
		check_status(name, s, cfg_rdata_o);
	endtask

	// ------------------------------
	// Tests

	task automatic test_base_decode();
		int e0;
		e0 = errors;
		run_one("addi", fetch_word(enc_i(12'hFFD, 5'd6, 3'b000, 5'd5, `DEC_OPC_OPIMM), 1'b0),
			make_dec(32'hFFFF_FFFD, 5'd6, 5'd0, 5'd5, ALUSRCA_RS1, ALUSRCB_IMM, ALUOP_ADD,
			MULOP_MUL, MEMOP_NONE, BCOND_NEVER, 1'b0, EXCEPT_NONE));
		run_one("lui", fetch_word({20'h12345, 5'd7, `DEC_OPC_LUI}, 1'b0),
			make_dec(32'h1234_5000, 5'd0, 5'd0, 5'd7, ALUSRCA_RS1, ALUSRCB_IMM, ALUOP_RS2,
			MULOP_MUL, MEMOP_NONE, BCOND_NEVER, 1'b0, EXCEPT_NONE));
		run_one("auipc", fetch_word({20'hABCDE, 5'd8, `DEC_OPC_AUIPC}, 1'b0),
			make_dec(32'hABCD_E000, 5'd0, 5'd0, 5'd8, ALUSRCA_PC, ALUSRCB_IMM, ALUOP_ADD,
			MULOP_MUL, MEMOP_NONE, BCOND_NEVER, 1'b0, EXCEPT_NONE));
		run_one("jal", fetch_word({20'h00100, 5'd1, `DEC_OPC_JAL}, 1'b0),
			make_dec(32'd4, 5'd0, 5'd0, 5'd1, ALUSRCA_PC, ALUSRCB_IMM, ALUOP_ADD,
			MULOP_MUL, MEMOP_NONE, BCOND_ALWAYS, 1'b0, EXCEPT_NONE));
		run_one("jalr", fetch_word(enc_i(12'd8, 5'd2, 3'b000, 5'd1, `DEC_OPC_JALR), 1'b0),
			make_dec(32'd4, 5'd2, 5'd0, 5'd1, ALUSRCA_PC, ALUSRCB_IMM, ALUOP_ADD,
			MULOP_MUL, MEMOP_NONE, BCOND_ALWAYS, 1'b1, EXCEPT_NONE));
		// BEQ +16 and BLTU -8 with their B immediates placed by hand
		run_one("beq", fetch_word({7'b0000000, 5'd4, 5'd3, 3'b000, 5'b10000,
			`DEC_OPC_BRANCH}, 1'b0),
			make_dec(32'd16, 5'd3, 5'd4, 5'd0, ALUSRCA_RS1, ALUSRCB_RS2, ALUOP_SUB,
			MULOP_MUL, MEMOP_NONE, BCOND_ZERO, 1'b0, EXCEPT_NONE));
		run_one("bltu", fetch_word({7'b1111111, 5'd4, 5'd3, 3'b110, 5'b11001,
			`DEC_OPC_BRANCH}, 1'b0),
			make_dec(32'hFFFF_FFF8, 5'd3, 5'd4, 5'd0, ALUSRCA_RS1, ALUSRCB_RS2, ALUOP_LTU,
			MULOP_MUL, MEMOP_NONE, BCOND_NZERO, 1'b0, EXCEPT_NONE));
		run_one("lw", fetch_word(enc_i(12'd12, 5'd10, 3'b010, 5'd9, `DEC_OPC_LOAD), 1'b0),
			make_dec(32'd12, 5'd10, 5'd0, 5'd9, ALUSRCA_RS1, ALUSRCB_RS2, ALUOP_ADD,
			MULOP_MUL, MEMOP_LW, BCOND_NEVER, 1'b1, EXCEPT_NONE));
		run_one("sw", fetch_word({7'd0, 5'd11, 5'd12, 3'b010, 5'd20, `DEC_OPC_STORE}, 1'b0),
			make_dec(32'd20, 5'd12, 5'd11, 5'd0, ALUSRCA_RS1, ALUSRCB_RS2, ALUOP_RS2,
			MULOP_MUL, MEMOP_SW, BCOND_NEVER, 1'b1, EXCEPT_NONE));
		run_one("add", fetch_word(enc_r(7'h00, 5'd15, 5'd14, 3'b000, 5'd13), 1'b0),
			make_dec(32'd15, 5'd14, 5'd15, 5'd13, ALUSRCA_RS1, ALUSRCB_RS2, ALUOP_ADD,
			MULOP_MUL, MEMOP_NONE, BCOND_NEVER, 1'b0, EXCEPT_NONE));
		run_one("sub", fetch_word(enc_r(7'h20, 5'd15, 5'd14, 3'b000, 5'd13), 1'b0),
			make_dec(32'h0000_040F, 5'd14, 5'd15, 5'd13, ALUSRCA_RS1, ALUSRCB_RS2, ALUOP_SUB,
			MULOP_MUL, MEMOP_NONE, BCOND_NEVER, 1'b0, EXCEPT_NONE));
		report_test("base_decode", e0);
	endtask

	task automatic test_pc_tracking();
		int e0;
		logic [31:0] w;
		e0 = errors;
		w = enc_i(12'd1, 5'd1, 3'b000, 5'd1, `DEC_OPC_OPIMM);
		for (int i = 0; i < 3; i++) begin
			run_one("pc_step", fetch_word(w, 1'b0), make_dec(32'd1, 5'd1, 5'd0, 5'd1,
				ALUSRCA_RS1, ALUSRCB_IMM, ALUOP_ADD, MULOP_MUL, MEMOP_NONE, BCOND_NEVER,
				1'b0, EXCEPT_NONE));
		end
		@(posedge clk);
		jump_valid_i  <= 1'b1;
		jump_target_i <= 32'h0000_1000;
		@(posedge clk);
		jump_valid_i <= 1'b0;
		exp_pc = 32'h0000_1000;
		for (int i = 0; i < 3; i++) begin
			run_one("pc_jump", fetch_word(w, 1'b0), make_dec(32'd1, 5'd1, 5'd0, 5'd1,
				ALUSRCA_RS1, ALUSRCB_IMM, ALUOP_ADD, MULOP_MUL, MEMOP_NONE, BCOND_NEVER,
				1'b0, EXCEPT_NONE));
		end
		report_test("pc_tracking", e0);
	endtask

	task automatic test_m_switch();
		int e0;
		logic [31:0] mul_w;
		logic [31:0] divu_w;
		e0 = errors;
		mul_w  = enc_r(7'h01, 5'd3, 5'd2, 3'b000, 5'd1);
		divu_w = enc_r(7'h01, 5'd3, 5'd2, 3'b101, 5'd1);
		write_cfg(1'b1, 1'b0);
		run_one("mul", fetch_word(mul_w, 1'b0), make_dec(32'd35, 5'd2, 5'd3, 5'd1,
			ALUSRCA_RS1, ALUSRCB_RS2, ALUOP_MULDIV, MULOP_MUL, MEMOP_NONE, BCOND_NEVER,
			1'b0, EXCEPT_NONE));
		run_one("divu", fetch_word(divu_w, 1'b0), make_dec(32'd35, 5'd2, 5'd3, 5'd1,
			ALUSRCA_RS1, ALUSRCB_RS2, ALUOP_MULDIV, MULOP_DIVU, MEMOP_NONE, BCOND_NEVER,
			1'b0, EXCEPT_NONE));
		write_cfg(1'b0, 1'b0);
		run_one("mul_off", fetch_word(mul_w, 1'b0), make_dec(32'd35, 5'd0, 5'd0, 5'd0,
			ALUSRCA_RS1, ALUSRCB_RS2, ALUOP_MULDIV, MULOP_MUL, MEMOP_NONE, BCOND_NEVER,
			1'b0, EXCEPT_ILLEGAL));
		expect_status("count_1", 16'd1, 1'b0);
		run_one("divu_off", fetch_word(divu_w, 1'b0), make_dec(32'd35, 5'd0, 5'd0, 5'd0,
			ALUSRCA_RS1, ALUSRCB_RS2, ALUOP_MULDIV, MULOP_DIVU, MEMOP_NONE, BCOND_NEVER,
			1'b0, EXCEPT_ILLEGAL));
		expect_status("count_2", 16'd2, 1'b0);
		write_cfg(1'b1, 1'b1);
		expect_status("count_clear", 16'd0, 1'b1);
		report_test("m_switch", e0);
	endtask

	task automatic test_fault_illegal();
		int e0;
		e0 = errors;
		run_one("fault", fetch_word(32'hFFFF_FFFF, 1'b1), make_dec(32'hFFFF_FFFF, 5'd0,
			5'd0, 5'd0, ALUSRCA_RS1, ALUSRCB_RS2, ALUOP_ADD, MULOP_MUL, MEMOP_NONE,
			BCOND_NEVER, 1'b0, EXCEPT_FAULT));
		expect_status("fault_uncounted", 16'd0, 1'b1);
		run_one("unknown", fetch_word(32'h0000_007F, 1'b0), make_dec(32'd0, 5'd0, 5'd0,
			5'd0, ALUSRCA_RS1, ALUSRCB_RS2, ALUOP_ADD, MULOP_MUL, MEMOP_NONE, BCOND_NEVER,
			1'b0, EXCEPT_ILLEGAL));
		expect_status("unknown_counted", 16'd1, 1'b1);
		run_one("ecall", fetch_word(32'h0000_0073, 1'b0), make_dec(32'd0, 5'd0, 5'd0, 5'd0,
			ALUSRCA_RS1, ALUSRCB_RS2, ALUOP_ADD, MULOP_MUL, MEMOP_NONE, BCOND_NEVER,
			1'b0, EXCEPT_ECALL));
		run_one("ebreak", fetch_word(32'h0010_0073, 1'b0), make_dec(32'd1, 5'd0, 5'd0,
			5'd0, ALUSRCA_RS1, ALUSRCB_RS2, ALUOP_ADD, MULOP_MUL, MEMOP_NONE, BCOND_NEVER,
			1'b0, EXCEPT_EBREAK));
		report_test("fault_illegal", e0);
	endtask

	task automatic test_backpressure();
		int   e0;
		dec_t exp_q[$];
		e0 = errors;
		fork
			begin
				logic [4:0]  rd;
				logic [4:0]  rs1;
				logic [11:0] imm;
				for (int i = 0; i < 40; i++) begin
					if (rand_bit()) begin
						@(posedge clk);
					end
					rd  = 5'(rand_bits(5));
					rs1 = 5'(rand_bits(5));
					imm = 12'(rand_bits(12));
					exp_q.push_back(make_dec(sext12(imm), rs1, 5'd0, rd, ALUSRCA_RS1,
						ALUSRCB_IMM, ALUOP_ADD, MULOP_MUL, MEMOP_NONE, BCOND_NEVER, 1'b0,
						EXCEPT_NONE));
					exp_pc = exp_pc + 32'd4;
					send_word(fetch_word(enc_i(imm, rs1, 3'b000, rd, `DEC_OPC_OPIMM), 1'b0));
				end
			end
			begin
				int got;
				int n;
				got = 0;
				n   = 0;
				while (got < 40) begin
					@(posedge clk);
					out_ready_i <= rand_bit();
					@(negedge clk);
					if (out_valid_o && out_ready_i) begin
						if (exp_q.size() == 0) begin
							$display("Output arrived with no instruction outstanding");
							errors++;
						end else begin
							check_dec("backpressure", exp_q.pop_front(), out_data_o);
						end
						got++;
						n = 0;
					end else begin
						n++;
						if (n > 500) begin
							abort_run("output stream stalled under back-pressure");
						end
					end
				end
				@(posedge clk);
				out_ready_i <= 1'b1;
			end
		join
		report_test("backpressure", e0);
	endtask

	initial begin
		clk           = 1'b0;
		rst_n         = 1'b0;
		in_valid_i    = 1'b0;
		in_data_i     = '0;
		out_ready_i   = 1'b1;
		jump_valid_i  = 1'b0;
		jump_target_i = '0;
		cfg_wr_i      = 1'b0;
		cfg_wdata_i   = '0;
		lfsr_state    = 16'd48;
		exp_pc        = `DEC_RESET_VECTOR;
		errors        = 0;
		tests         = 0;
		failed_tests  = 0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		test_base_decode();
		test_pc_tracking();
		test_m_switch();
		test_fault_illegal();
		test_backpressure();
		$display("Tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== test/rv_decode_asserts.sv ====
// Concurrent checks on the decode stage handshakes and decoded output, bound to the top level
`timescale 1ns/1ps
`default_nettype none

module rv_decode_asserts import rv_decode_pkg::*; (
	input wire logic   clk,
	input wire logic   rst_n,
	input wire logic   in_valid_i,
	input wire logic   in_ready_o,
	input wire fetch_t in_data_i,
	input wire logic   out_valid_o,
	input wire logic   out_ready_i,
	input wire dec_t   out_data_o
);

	// ------------------------------
	// Handshake stability

	out_hold: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o))
		else $error("output changed while stalled");

	in_hold: assert property (@(posedge clk) disable iff (!rst_n)
		in_valid_i && !in_ready_o |=> in_valid_i && $stable(in_data_i))
		else $error("input changed while stalled");

	out_idle_after_reset: assert property (@(posedge clk)
		rst_n && !$past(rst_n) |-> !out_valid_o)
		else $error("output valid right after reset");

	// Exceptions from a bad word never write a register
	except_no_rd: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid_o && (out_data_o.except == EXCEPT_ILLEGAL
			|| out_data_o.except == EXCEPT_FAULT) |-> out_data_o.rd == '0)
		else $error("exception output with nonzero rd");

endmodule

bind rv_decode_top rv_decode_asserts u_asserts (
	.clk         (clk),
	.rst_n       (rst_n),
	.in_valid_i  (in_valid_i),
	.in_ready_o  (in_ready_o),
	.in_data_i   (in_data_i),
	.out_valid_o (out_valid_o),
	.out_ready_i (out_ready_i),
	.out_data_o  (out_data_o)
);

`default_nettype wire

// ==== src/rv_decode_top.sv ====
// Decode stage top level joining fetch slice, decoder, PC tracker, configuration and output slice
`timescale 1ns/1ps
`default_nettype none
`include "rv_decode_consts.svh"

module rv_decode_top import rv_decode_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_n,

	input  logic                 in_valid_i,
	output logic                 in_ready_o,
	input  fetch_t               in_data_i,

	output logic                 out_valid_o,
	input  logic                 out_ready_i,
	output dec_t                 out_data_o,

	input  logic                 jump_valid_i,
	input  logic [`DEC_XLEN-1:0] jump_target_i,

	input  logic                 cfg_wr_i,
	input  cfg_write_t           cfg_wdata_i,
	output cfg_status_t          cfg_rdata_o
);

	fetch_t               fetch_data;
	logic                 fetch_valid;
	logic                 fetch_ready;
	dec_t                 dec_data;
	logic [`DEC_XLEN-1:0] dec_pc;
	logic                 m_en;
	logic                 issue;
	logic                 issue_illegal;

	// ------------------------------
	// Issue is the move from the fetch slice into the output slice

	assign issue         = fetch_valid && fetch_ready;
	assign issue_illegal = issue && dec_data.except == EXCEPT_ILLEGAL;

	pipe_stage #(.T_PAYLOAD(fetch_t)) u_fetch_stage (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_valid_i  (in_valid_i),
		.in_ready_o  (in_ready_o),
		.in_data_i   (in_data_i),
		.out_valid_o (fetch_valid),
		.out_ready_i (fetch_ready),
		.out_data_o  (fetch_data)
	);

	op_decoder u_op_decoder (
		.fetch_i (fetch_data),
		.pc_i    (dec_pc),
		.m_en_i  (m_en),
		.dec_o   (dec_data)
	);

	pc_tracker u_pc_tracker (
		.clk           (clk),
		.rst_n         (rst_n),
		.issue_i       (issue),
		.jump_valid_i  (jump_valid_i),
		.jump_target_i (jump_target_i),
		.pc_o          (dec_pc)
	);

	decode_cfg u_decode_cfg (
		.clk             (clk),
		.rst_n           (rst_n),
		.cfg_wr_i        (cfg_wr_i),
		.cfg_wdata_i     (cfg_wdata_i),
		.issue_illegal_i (issue_illegal),
		.m_en_o          (m_en),
		.cfg_rdata_o     (cfg_rdata_o)
	);

	pipe_stage #(.T_PAYLOAD(dec_t)) u_dec_stage (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_valid_i  (fetch_valid),
		.in_ready_o  (fetch_ready),
		.in_data_i   (dec_data),
		.out_valid_o (out_valid_o),
		.out_ready_i (out_ready_i),
		.out_data_o  (out_data_o)
	);

endmodule

`default_nettype wire

// ==== src/decode_cfg.sv ====
// Decode configuration register with M-extension enable and saturating illegal-instruction count
`timescale 1ns/1ps
`default_nettype none
`include "rv_decode_consts.svh"

module decode_cfg import rv_decode_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,

	input  logic        cfg_wr_i,
	input  cfg_write_t  cfg_wdata_i,
	input  logic        issue_illegal_i,

	output logic        m_en_o,
	output cfg_status_t cfg_rdata_o
);

	logic                      m_en_q;
	logic [`DEC_ILL_CNT_W-1:0] ill_count_q;

	assign m_en_o                = m_en_q;
	assign cfg_rdata_o.m_en      = m_en_q;
	assign cfg_rdata_o.ill_count = ill_count_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			m_en_q <= `DEC_RESET_M_EN;
		end else if (cfg_wr_i) begin
			m_en_q <= cfg_wdata_i.m_en;
		end
	end

	// Clear wins over a count on the same edge, the count sticks at all ones
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ill_count_q <= '0;
		end else if (cfg_wr_i && cfg_wdata_i.clr_count) begin
			ill_count_q <= '0;
		end else if (issue_illegal_i && ill_count_q != '1) begin
			ill_count_q <= ill_count_q + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== src/pc_tracker.sv ====
// PC of the next instruction to issue, stepped by 4 per issue and loaded by a jump redirect
`timescale 1ns/1ps
`default_nettype none
`include "rv_decode_consts.svh"

module pc_tracker (
	input  logic                 clk,
	input  logic                 rst_n,

	input  logic                 issue_i,
	input  logic                 jump_valid_i,
	input  logic [`DEC_XLEN-1:0] jump_target_i,

	output logic [`DEC_XLEN-1:0] pc_o
);

	// Only whole 32-bit words reach this stage
	localparam logic [`DEC_XLEN-1:0] PC_STEP = 4;

	logic [`DEC_XLEN-1:0] pc_q;

	assign pc_o = pc_q;

	// An issue on the redirect edge keeps the old PC, the target applies after it
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc_q <= `DEC_RESET_VECTOR;
		end else if (jump_valid_i) begin
			pc_q <= jump_target_i;
		end else if (issue_i) begin
			pc_q <= pc_q + PC_STEP;
		end
	end

endmodule

`default_nettype wire

// ==== src/op_decoder.sv ====
// Combinational RV32IM decode of one fetched word into the decoded control struct
`timescale 1ns/1ps
`default_nettype none
`include "rv_decode_consts.svh"

module op_decoder import rv_decode_pkg::*; (
	input  fetch_t               fetch_i,
	input  logic [`DEC_XLEN-1:0] pc_i,
	input  logic                 m_en_i,
	output dec_t                 dec_o
);

	localparam logic [`DEC_REGADDR_W-1:0] X0 = '0;
	localparam logic [`DEC_XLEN-1:0] LINK_OFFS = 4;

	logic [`DEC_XLEN-1:0] instr;
	logic [6:0]           opcode;
	logic [2:0]           funct3;
	logic [6:0]           funct7;
	logic [`DEC_XLEN-1:0] imm_i;
	logic [`DEC_XLEN-1:0] imm_s;
	logic [`DEC_XLEN-1:0] imm_b;
	logic [`DEC_XLEN-1:0] imm_u;
	logic                 illegal;

	// ALU op shared by OP and OP-IMM, alt selects SUB or SRA
	function automatic aluop_e alu_from_funct(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000:  alu_from_funct = alt ? ALUOP_SUB : ALUOP_ADD;
			3'b001:  alu_from_funct = ALUOP_SLL;
			3'b010:  alu_from_funct = ALUOP_LT;
			3'b011:  alu_from_funct = ALUOP_LTU;
			3'b100:  alu_from_funct = ALUOP_XOR;
			3'b101:  alu_from_funct = alt ? ALUOP_SRA : ALUOP_SRL;
			3'b110:  alu_from_funct = ALUOP_OR;
			default: alu_from_funct = ALUOP_AND;
		endcase
	endfunction

	assign instr  = fetch_i.instr;
	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	assign imm_i = {{21{instr[31]}}, instr[30:20]};
	assign imm_s = {{21{instr[31]}}, instr[30:25], instr[11:7]};
	assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'h000};

	always_comb begin
		dec_o                 = '0;
		dec_o.pc              = pc_i;
		dec_o.imm             = imm_i;
		dec_o.rs1             = instr[19:15];
		dec_o.rs2             = instr[24:20];
		dec_o.rd              = instr[11:7];
		dec_o.alusrc_a        = ALUSRCA_RS1;
		dec_o.alusrc_b        = ALUSRCB_RS2;
		dec_o.aluop           = ALUOP_ADD;
		dec_o.mulop           = MULOP_MUL;
		dec_o.memop           = MEMOP_NONE;
		dec_o.branchcond      = BCOND_NEVER;
		dec_o.addr_is_regoffs = 1'b0;
		dec_o.except          = EXCEPT_NONE;
		illegal               = 1'b0;

		case (opcode)
			`DEC_OPC_OPIMM: begin
				dec_o.alusrc_b = ALUSRCB_IMM;
				dec_o.rs2      = X0;
				dec_o.aluop    = alu_from_funct(funct3, funct3 == 3'b101 && funct7[5]);
				if (funct3 == 3'b001) begin
					illegal = funct7 != 7'b0000000;
				end else if (funct3 == 3'b101) begin
					illegal = funct7 != 7'b0000000 && funct7 != 7'b0100000;
				end
			end
			`DEC_OPC_OP: begin
				dec_o.aluop = alu_from_funct(funct3, funct7[5]);
				if (funct7 == 7'b0000001) begin
					// M extension, legal only while enabled
					dec_o.aluop = ALUOP_MULDIV;
					dec_o.mulop = mulop_e'(funct3);
					illegal     = !m_en_i;
				end else if (funct7 == 7'b0100000) begin
					illegal = funct3 != 3'b000 && funct3 != 3'b101;
				end else begin
					illegal = funct7 != 7'b0000000;
				end
			end
			`DEC_OPC_LUI: begin
				dec_o.imm      = imm_u;
				dec_o.alusrc_b = ALUSRCB_IMM;
				dec_o.aluop    = ALUOP_RS2;
				dec_o.rs1      = X0;
				dec_o.rs2      = X0;
			end
			`DEC_OPC_AUIPC: begin
				dec_o.imm      = imm_u;
				dec_o.alusrc_a = ALUSRCA_PC;
				dec_o.alusrc_b = ALUSRCB_IMM;
				dec_o.rs1      = X0;
				dec_o.rs2      = X0;
			end
			`DEC_OPC_JAL, `DEC_OPC_JALR: begin
				// The ALU forms the link address pc + 4
				dec_o.imm        = LINK_OFFS;
				dec_o.alusrc_a   = ALUSRCA_PC;
				dec_o.alusrc_b   = ALUSRCB_IMM;
				dec_o.branchcond = BCOND_ALWAYS;
				dec_o.rs2        = X0;
				if (opcode == `DEC_OPC_JAL) begin
					dec_o.rs1 = X0;
				end else begin
					dec_o.addr_is_regoffs = 1'b1;
					illegal               = funct3 != 3'b000;
				end
			end
			`DEC_OPC_BRANCH: begin
				dec_o.imm        = imm_b;
				dec_o.rd         = X0;
				dec_o.aluop      = !funct3[2] ? ALUOP_SUB : funct3[1] ? ALUOP_LTU : ALUOP_LT;
				dec_o.branchcond = (funct3[0] ^ funct3[2]) ? BCOND_NZERO : BCOND_ZERO;
				illegal          = funct3[2:1] == 2'b01;
			end
			`DEC_OPC_LOAD: begin
				dec_o.addr_is_regoffs = 1'b1;
				dec_o.rs2             = X0;
				case (funct3)
					3'b000:  dec_o.memop = MEMOP_LB;
					3'b001:  dec_o.memop = MEMOP_LH;
					3'b010:  dec_o.memop = MEMOP_LW;
					3'b100:  dec_o.memop = MEMOP_LBU;
					3'b101:  dec_o.memop = MEMOP_LHU;
					default: illegal = 1'b1;
				endcase
			end
			`DEC_OPC_STORE: begin
				dec_o.imm             = imm_s;
				dec_o.addr_is_regoffs = 1'b1;
				dec_o.aluop           = ALUOP_RS2;
				dec_o.rd              = X0;
				case (funct3)
					3'b000:  dec_o.memop = MEMOP_SB;
					3'b001:  dec_o.memop = MEMOP_SH;
					3'b010:  dec_o.memop = MEMOP_SW;
					default: illegal = 1'b1;
				endcase
			end
			`DEC_OPC_FENCE: begin
				// Executes as a no-op, FENCE.I is not supported
				dec_o.rs2 = X0;
				illegal   = funct3 != 3'b000;
			end
			`DEC_OPC_SYSTEM: begin
				dec_o.rs1 = X0;
				dec_o.rs2 = X0;
				dec_o.rd  = X0;
				if (instr[31:7] == 25'h0000000) begin
					dec_o.except = EXCEPT_ECALL;
				end else if (instr[31:7] == {12'h001, 13'h0000}) begin
					dec_o.except = EXCEPT_EBREAK;
				end else begin
					illegal = 1'b1;
				end
			end
			default: illegal = 1'b1;
		endcase

		// A fetch fault outranks whatever the word decoded to
		if (fetch_i.err || illegal) begin
			dec_o.rs1        = X0;
			dec_o.rs2        = X0;
			dec_o.rd         = X0;
			dec_o.memop      = MEMOP_NONE;
			dec_o.branchcond = BCOND_NEVER;
			dec_o.except     = fetch_i.err ? EXCEPT_FAULT : EXCEPT_ILLEGAL;
		end
	end

endmodule

`default_nettype wire

// ==== src/pipe_stage.sv ====
// One-entry valid/ready register slice, instantiated with the payload type it carries
`timescale 1ns/1ps
`default_nettype none

module pipe_stage #(
	parameter type T_PAYLOAD = logic
) (
	input  logic     clk,
	input  logic     rst_n,

	input  logic     in_valid_i,
	output logic     in_ready_o,
	input  T_PAYLOAD in_data_i,

	output logic     out_valid_o,
	input  logic     out_ready_i,
	output T_PAYLOAD out_data_o
);

	logic     valid_q;
	T_PAYLOAD data_q;

	// Accept when empty, or when the held item leaves on this same edge
	assign in_ready_o  = !valid_q || out_ready_i;
	assign out_valid_o = valid_q;
	assign out_data_o  = data_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
		end else if (in_ready_o) begin
			valid_q <= in_valid_i;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid_i && in_ready_o) begin
			data_q <= in_data_i;
		end
	end

endmodule

`default_nettype wire

// ==== src/rv_decode_pkg.sv ====
// Enumerated types and packed structs shared by the decode stage RTL and its testbench
`default_nettype none
`include "rv_decode_consts.svh"

package rv_decode_pkg;

	// ------------------------------
	// Control encodings

	typedef enum logic [3:0] {
		ALUOP_ADD, ALUOP_SUB, ALUOP_SLL, ALUOP_LT, ALUOP_LTU, ALUOP_XOR,
		ALUOP_SRL, ALUOP_SRA, ALUOP_OR, ALUOP_AND, ALUOP_RS2, ALUOP_MULDIV
	} aluop_e;

	// Order follows funct3 of the M extension
	typedef enum logic [2:0] {
		MULOP_MUL, MULOP_MULH, MULOP_MULHSU, MULOP_MULHU,
		MULOP_DIV, MULOP_DIVU, MULOP_REM, MULOP_REMU
	} mulop_e;

	typedef enum logic [3:0] {
		MEMOP_NONE, MEMOP_LB, MEMOP_LH, MEMOP_LW, MEMOP_LBU,
		MEMOP_LHU, MEMOP_SB, MEMOP_SH, MEMOP_SW
	} memop_e;

	typedef enum logic [1:0] {BCOND_NEVER, BCOND_ZERO, BCOND_NZERO, BCOND_ALWAYS} bcond_e;

	typedef enum logic [2:0] {
		EXCEPT_NONE, EXCEPT_ILLEGAL, EXCEPT_FAULT, EXCEPT_ECALL, EXCEPT_EBREAK
	} except_e;

	typedef enum logic {ALUSRCA_RS1, ALUSRCA_PC} alusrc_a_e;
	typedef enum logic {ALUSRCB_RS2, ALUSRCB_IMM} alusrc_b_e;

	// ------------------------------
	// Payloads

	// Instruction word as fetched, err marks a faulting fetch
	typedef struct packed {
		logic [`DEC_XLEN-1:0] instr;
		logic                 err;
	} fetch_t;

	typedef struct packed {
		logic [`DEC_XLEN-1:0]      pc;
		logic [`DEC_XLEN-1:0]      imm;
		logic [`DEC_REGADDR_W-1:0] rs1;
		logic [`DEC_REGADDR_W-1:0] rs2;
		logic [`DEC_REGADDR_W-1:0] rd;
		alusrc_a_e                 alusrc_a;
		alusrc_b_e                 alusrc_b;
		aluop_e                    aluop;
		mulop_e                    mulop;
		memop_e                    memop;
		bcond_e                    branchcond;
		logic                      addr_is_regoffs;
		except_e                   except;
	} dec_t;

	typedef struct packed {
		logic [`DEC_ILL_CNT_W-1:0] ill_count;
		logic                      m_en;
	} cfg_status_t;

	typedef struct packed {
		logic m_en;
		logic clr_count;
	} cfg_write_t;

endpackage

`default_nettype wire

// ==== src/rv_decode_consts.svh ====
// Widths, reset values and RV32 major opcodes for the decode stage, included by the package and RTL
`ifndef RV_DECODE_CONSTS_SVH
`define RV_DECODE_CONSTS_SVH

// ------------------------------
// Widths

// Data, address and instruction word width
`define DEC_XLEN          32
`define DEC_REGADDR_W     5
`define DEC_ILL_CNT_W     16

// ------------------------------
// Reset values

`define DEC_RESET_VECTOR  32'h0000_0080
`define DEC_RESET_M_EN    1'b1

// ------------------------------
// Major opcodes, bits [6:0] of the instruction word

`define DEC_OPC_LOAD      7'b0000011
`define DEC_OPC_STORE     7'b0100011
`define DEC_OPC_BRANCH    7'b1100011
`define DEC_OPC_JAL       7'b1101111
`define DEC_OPC_JALR      7'b1100111
`define DEC_OPC_LUI       7'b0110111
`define DEC_OPC_AUIPC     7'b0010111
`define DEC_OPC_OPIMM     7'b0010011
`define DEC_OPC_OP        7'b0110011
`define DEC_OPC_FENCE     7'b0001111
`define DEC_OPC_SYSTEM    7'b1110011

`endif
